/* build.f */
+incdir+testbench
common/aes_pkg.sv
design/aes_sbox.sv
aes_round/aes_enc_ctrl.sv
aes_round/aes_enc_datapath.sv
design/aes_encipher_top.sv
testbench/aes_encipher_chk.sv
testbench/tb_aes_encipher.sv

/* Bender.yml */
package:
  name: aes_encipher

sources:
  - files:
      - common/aes_pkg.sv
      - design/aes_sbox.sv
      - aes_round/aes_enc_ctrl.sv
      - aes_round/aes_enc_datapath.sv
      - design/aes_encipher_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/aes_encipher_chk.sv
      - testbench/tb_aes_encipher.sv

/* testbench/aes_vectors.svh */
/*
  Known-answer data for the AES encipher testbench.
  Round keys are the FIPS-197 expansions of keys 000102..0f and 000102..1f.
  No key schedule runs in the testbench. Keys are indexed by round number.
  Included inside the testbench module.
*/

`ifndef AES_VECTORS_SVH
`define AES_VECTORS_SVH

  // plaintext shared by every run
  localparam logic [127:0] PLAIN_BLOCK = 128'h00112233445566778899aabbccddeeff;

  // expected ciphertexts
  localparam logic [127:0] CIPHER_128 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [127:0] CIPHER_256 = 128'h8ea2b7ca516745bfeafc49904b496089;

  // aes-128 round keys 0 to 10
  localparam logic [127:0] KEYS128 [0:10] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
    128'hb692cf0b643dbdf1be9bc5006830b3fe, 128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
    128'h47f7f7bc95353e03f96c32bcfd058dfd, 128'h3caaa3e8a99f9deb50f3af57adf622aa,
    128'h5e390f7df7a69296a7553dc10aa31f6b, 128'h14f9701ae35fe28c440adf4d4ea9c026,
    128'h47438735a41c65b9e016baf4aebf7ad2, 128'h549932d1f08557681093ed9cbe2c974e,
    128'h13111d7fe3944a17f307a78b4d2b30c5
  };

  // aes-256 round keys 0 to 14
  localparam logic [127:0] KEYS256 [0:14] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'h101112131415161718191a1b1c1d1e1f,
    128'ha573c29fa176c498a97fce93a572c09c, 128'h1651a8cd0244beda1a5da4c10640bade,
    128'hae87dff00ff11b68a68ed5fb03fc1567, 128'h6de1f1486fa54f9275f8eb5373b8518d,
    128'hc656827fc9a799176f294cec6cd5598b, 128'h3de23a75524775e727bf9eb45407cf39,
    128'h0bdc905fc27b0948ad5245a4c1871c2f, 128'h45f5a66017b2d387300d4d33640a820a,
    128'h7ccff71cbeb4fe5413e6bbf0d261a7df, 128'hf01afafee7a82979d7a5644ab3afe640,
    128'h2541fe719bf500258813bbd55a721c0a, 128'h4e5a6699a9f24fe07e572baacdf8cdea,
    128'h24fc79ccbf0979e9371ac23c6d68de36
  };

`endif

/* testbench/tb_aes_encipher.sv */
/*
  Testbench for the AES encipher engine, AES-128 and AES-256 known answers.
  Round keys come from fixed tables, indexed by the round the DUT drives.
  Stray next pulses during a run are placed by an LCG with a fixed seed.
  Every wait for ready gives up after TIMEOUT_CYCLES clock cycles.
*/

`timescale 1ns/1ps

module tb_aes_encipher
  import aes_pkg::*;
();

  `include "aes_vectors.svh"

  localparam int TIMEOUT_CYCLES = 200;
  localparam int STRAY_PULSES   = 3;

  logic        clk;
  logic        reset_n;
  logic        next;
  logic        keylen;
  aes_state_t  block;
  aes_state_t  round_key;
  round_idx_t  round;
  aes_state_t  new_block;
  logic        ready;
  logic [31:0] lcg_state;

  // key source follows the round the DUT asks for
  assign round_key = keylen ? KEYS256[round] : KEYS128[round];

  aes_encipher_top i_aes_encipher_top (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .round_key (round_key),
    .block     (block),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic report_failure(input string cause);
    $display("%s", cause);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
    assert (actual === expected)
    else
    begin
      report_failure($sformatf("ERR %0t %s expected %0h actual %0h",
                               $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // returns in the time step where ready reaches level
  task automatic wait_for_ready(input logic level);
    int cycles;
    cycles = 0;
    while (ready !== level)
    begin
      @(ready or negedge clk);
      if (ready !== level)
      begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
          report_failure($sformatf("timeout, ready never went to %0b", level));
        end
      end
    end
  endtask

  // one-cycle next with block and key length
  task automatic start_run(input logic use_256);
    next   <= 1'b1;
    keylen <= use_256;
    block  <= PLAIN_BLOCK;
    @(posedge clk);
    next   <= 1'b0;
  endtask

  // at most 39 cycles, well inside the shortest run
  task automatic send_stray_pulses(input int count);
    int gap;
    for (int i = 0; i < count; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      gap = 1 + int'(lcg_state[27:24]) % 12;
      repeat (gap) @(posedge clk);
      next <= 1'b1;
      @(posedge clk);
      next <= 1'b0;
    end
  endtask

  task automatic verify_ciphertext(input string name, input logic [127:0] expected);
    @(negedge clk);
    expect_value(name, expected, new_block);
  endtask

  // bound checker errors end the run at once
  always @(negedge clk)
  begin
    if (i_aes_encipher_top.i_aes_encipher_chk.fail_count != 0)
    begin
      report_failure("a bound protocol assertion failed, see the error above");
    end
  end

  initial
  begin
    clk       = 1'b0;
    reset_n   = 1'b0;
    next      = 1'b0;
    keylen    = 1'b0;
    block     = '0;
    lcg_state = 32'hcdba_5b60;

    repeat (10) @(posedge clk);
    reset_n <= 1'b1;

    // ---------------------------------------------------------------------
    // idle state after reset
    // ---------------------------------------------------------------------
    @(negedge clk);
    expect_value("ready", 128'd1, 128'(ready));
    expect_value("round", 128'd0, 128'(round));

    // aes-128 with stray next pulses
    @(posedge clk);
    start_run(1'b0);
    wait_for_ready(1'b0);
    send_stray_pulses(STRAY_PULSES);
    wait_for_ready(1'b1);
    verify_ciphertext("new_block aes-128", CIPHER_128);

    // aes-256 with stray next pulses
    @(posedge clk);
    start_run(1'b1);
    wait_for_ready(1'b0);
    send_stray_pulses(STRAY_PULSES);
    wait_for_ready(1'b1);
    verify_ciphertext("new_block aes-256", CIPHER_256);

    // ---------------------------------------------------------------------
    // back to back, aes-256 issued on the edge that raises ready
    // ---------------------------------------------------------------------
    @(posedge clk);
    start_run(1'b0);
    wait_for_ready(1'b0);
    wait_for_ready(1'b1);
    start_run(1'b1);
    verify_ciphertext("new_block aes-128 before restart", CIPHER_128);
    wait_for_ready(1'b0);
    wait_for_ready(1'b1);
    verify_ciphertext("new_block aes-256 back to back", CIPHER_256);

    // idle tail so the stability check runs
    repeat (5) @(posedge clk);
    // assertion actions of the last edge have run by now
    @(negedge clk);
    if (i_aes_encipher_top.i_aes_encipher_chk.fail_count == 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
    begin
      report_failure("a bound protocol assertion failed during the run");
    end
  end

endmodule

/* testbench/aes_encipher_chk.sv */
/*
  Protocol and latency checks, bound into the AES encipher top level.
  Latency counts from the edge that accepts next with ready high.
  Failed assertions raise $error and bump fail_count for the testbench.
*/

`timescale 1ns/1ps

module aes_encipher_chk
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       keylen,
  input  logic       ready,
  input  round_idx_t round,
  input  aes_state_t new_block
);

  // failed assertions so far
  int fail_count = 0;

  // key length of the run in progress
  logic run_256;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      run_256 <= 1'b0;
    end
    else if (next && ready)
    begin
      run_256 <= keylen;
    end
  end

  // ---------------------------------------------------------------------
  // handshake and latency
  // ---------------------------------------------------------------------

  // busy right after an accepted next
  assert property (@(posedge clk) disable iff (!reset_n) (next && ready) |=> !ready)
  else
  begin
    $error("ready stayed high after an accepted next");
    fail_count++;
  end

  // 1 + 5 * 10 cycles
  assert property (@(posedge clk) disable iff (!reset_n)
    (next && ready && !keylen) |=> !ready [*51] ##1 ready)
  else
  begin
    $error("aes-128 run did not finish in 51 cycles");
    fail_count++;
  end

  // 1 + 5 * 14 cycles
  assert property (@(posedge clk) disable iff (!reset_n)
    (next && ready && keylen) |=> !ready [*71] ##1 ready)
  else
  begin
    $error("aes-256 run did not finish in 71 cycles");
    fail_count++;
  end

  // result held while idle
  assert property (@(posedge clk) disable iff (!reset_n)
    (ready && $past(ready)) |-> $stable(new_block))
  else
  begin
    $error("new_block changed while ready was high");
    fail_count++;
  end

  // ---------------------------------------------------------------------
  // round range
  // ---------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!reset_n) round <= AES256_ROUNDS)
  else
  begin
    $error("round went past 14");
    fail_count++;
  end

  assert property (@(posedge clk) disable iff (!reset_n)
    !run_256 |-> round <= AES128_ROUNDS)
  else
  begin
    $error("round went past 10 in an aes-128 run");
    fail_count++;
  end

endmodule

bind aes_encipher_top aes_encipher_chk i_aes_encipher_chk (
  .clk       (clk),
  .reset_n   (reset_n),
  .next      (next),
  .keylen    (keylen),
  .ready     (ready),
  .round     (round),
  .new_block (new_block)
);

/* design/aes_encipher_top.sv */
/*
  AES-128 and AES-256 encipher engine without key expansion.
  The engine drives round and expects the matching round_key in the same
  cycle, combinationally. next is a one-cycle strobe and is ignored while
  ready is low. keylen is 0 for AES-128, 1 for AES-256.
  new_block holds the ciphertext while ready is high.
*/

`timescale 1ns/1ps

module aes_encipher_top
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       keylen,
  input  aes_state_t round_key,
  input  aes_state_t block,
  output round_idx_t round,
  output aes_state_t new_block,
  output logic       ready
);

  // control to datapath
  round_op_t  op;
  logic [1:0] sword_idx;

  // datapath to s-box and back
  aes_word_t  sbox_in;
  aes_word_t  sbox_out;

  // sequencing, counters and ready
  aes_enc_ctrl i_aes_enc_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .op        (op),
    .sword_idx (sword_idx),
    .round     (round),
    .ready     (ready)
  );

  // state and round transforms
  aes_enc_datapath i_aes_enc_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .op        (op),
    .sword_idx (sword_idx),
    .block     (block),
    .round_key (round_key),
    .sbox_out  (sbox_out),
    .sbox_in   (sbox_in),
    .new_block (new_block)
  );

  // shared word s-box
  aes_sbox i_aes_sbox (
    .in  (sbox_in),
    .out (sbox_out)
  );

endmodule

/* aes_round/aes_enc_datapath.sv */
/*
  State register and round datapath of the AES encipher engine.
  SubBytes runs one word per cycle through an external combinational S-box.
  ShiftRows, MixColumns and AddRoundKey complete in a single cycle.
  round_key must match the round number for the current cycle.
  The datapath only follows op. It makes no sequencing decisions.
*/

`timescale 1ns/1ps

module aes_enc_datapath
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  round_op_t  op,
  input  logic [1:0] sword_idx,
  input  aes_state_t block,
  input  aes_state_t round_key,
  input  aes_word_t  sbox_out,
  output aes_word_t  sbox_in,
  output aes_state_t new_block
);

  aes_state_t state_reg;
  aes_state_t state_next;

  // intermediate round values
  aes_state_t shifted;
  aes_state_t mixed;

  // word under substitution
  assign sbox_in = state_reg.words[sword_idx];

  // state already holds the ciphertext once ready rises
  assign new_block = state_reg;

  // ---------------------------------------------------------------------
  // shiftrows
  // ---------------------------------------------------------------------
  always_comb
  begin
    // row r rotates left by r columns
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted.bytes[4 * c + r] = state_reg.bytes[4 * ((c + r) % 4) + r];
      end
    end
  end

  // ---------------------------------------------------------------------
  // mixcolumns
  // ---------------------------------------------------------------------
  always_comb
  begin
    logic [0:3][7:0] col;

    // every term taken from the shifted column
    for (int c = 0; c < 4; c++)
    begin
      col = shifted.words[c];
      mixed.bytes[4 * c + 0] = gm2(col[0]) ^ gm3(col[1]) ^ col[2] ^ col[3];
      mixed.bytes[4 * c + 1] = col[0] ^ gm2(col[1]) ^ gm3(col[2]) ^ col[3];
      mixed.bytes[4 * c + 2] = col[0] ^ col[1] ^ gm2(col[2]) ^ gm3(col[3]);
      mixed.bytes[4 * c + 3] = gm3(col[0]) ^ col[1] ^ col[2] ^ gm2(col[3]);
    end
  end

  // ---------------------------------------------------------------------
  // state update per op
  // ---------------------------------------------------------------------
  always_comb
  begin
    state_next = state_reg;

    case (op)
      OP_INIT:
      begin
        // initial addroundkey with key 0
        state_next = block ^ round_key;
      end

      OP_SUB:
      begin
        // write back the substituted word
        state_next.words[sword_idx] = sbox_out;
      end

      OP_MIX:
      begin
        state_next = mixed ^ round_key;
      end

      OP_FINAL:
      begin
        // last round has no mixcolumns
        state_next = shifted ^ round_key;
      end

      default:
      begin
        // idle holds the last result
        state_next = state_reg;
      end
    endcase
  end

  // ---------------------------------------------------------------------
  // state register
  // ---------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= '0;
    end
    else
    begin
      state_reg <= state_next;
    end
  end

endmodule

/* aes_round/aes_enc_ctrl.sv */
/*
  Control FSM for the AES encipher engine.
  next is taken only while ready is high. keylen is latched with it.
  Each round is four OP_SUB cycles then one OP_MIX, or OP_FINAL in the
  last round. Ready rises 1 + 5 * Nr cycles after the accepting edge.
  The engine cannot be stopped once a block has been accepted.
*/

`timescale 1ns/1ps

module aes_enc_ctrl
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       keylen,
  output round_op_t  op,
  output logic [1:0] sword_idx,
  output round_idx_t round,
  output logic       ready
);

  // next-state values
  round_op_t  op_next;
  logic [1:0] sword_next;
  round_idx_t round_next;
  logic       ready_next;
  logic       keylen_next;

  // latched key length, 1 selects aes-256
  logic       keylen_reg;
  round_idx_t last_round;

  assign last_round = keylen_reg ? AES256_ROUNDS : AES128_ROUNDS;

  // ---------------------------------------------------------------------
  // registers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      op         <= OP_IDLE;
      sword_idx  <= '0;
      round      <= '0;
      ready      <= 1'b1;
      keylen_reg <= 1'b0;
    end
    else
    begin
      op         <= op_next;
      sword_idx  <= sword_next;
      round      <= round_next;
      ready      <= ready_next;
      keylen_reg <= keylen_next;
    end
  end

  // ---------------------------------------------------------------------
  // fsm, the registered op doubles as the state
  // ---------------------------------------------------------------------
  always_comb
  begin
    op_next     = op;
    sword_next  = sword_idx;
    round_next  = round;
    ready_next  = ready;
    keylen_next = keylen_reg;

    case (op)
      OP_IDLE:
      begin
        // stray next while busy never reaches here
        if (next && ready)
        begin
          op_next     = OP_INIT;
          ready_next  = 1'b0;
          keylen_next = keylen;
          round_next  = '0;
          sword_next  = '0;
        end
      end

      OP_INIT:
      begin
        // key 0 was added this cycle
        op_next    = OP_SUB;
        round_next = round + 4'd1;
        sword_next = '0;
      end

      OP_SUB:
      begin
        // counter wraps to 0 after the last word
        sword_next = sword_idx + 2'd1;
        if (sword_idx == 2'(SBOX_WORDS - 1))
        begin
          op_next = (round == last_round) ? OP_FINAL : OP_MIX;
        end
      end

      OP_MIX:
      begin
        op_next    = OP_SUB;
        round_next = round + 4'd1;
      end

      OP_FINAL:
      begin
        // result lands in the state on this edge
        op_next    = OP_IDLE;
        ready_next = 1'b1;
        round_next = '0;
      end

      default:
      begin
        op_next    = OP_IDLE;
        ready_next = 1'b1;
        round_next = '0;
      end
    endcase
  end

endmodule

/* design/aes_sbox.sv */
/*
  Forward AES S-box on one 32-bit word.
  All four bytes are looked up in parallel from one 256-entry table.
  Purely combinational. The result is valid in the same cycle.
  No inverse table is provided.
*/

`timescale 1ns/1ps

module aes_sbox
  import aes_pkg::*;
(
  input  aes_word_t in,
  output aes_word_t out
);

  // ---------------------------------------------------------------------
  // forward s-box, entry i is sub(i)
  // ---------------------------------------------------------------------
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // ---------------------------------------------------------------------
  // four byte lanes
  // ---------------------------------------------------------------------
  always_comb
  begin
    // lane i covers bits 8i+7 down to 8i
    for (int i = 0; i < 4; i++)
    begin
      out[8 * i +: 8] = SBOX[in[8 * i +: 8]];
    end
  end

endmodule

/* common/aes_pkg.sv */
/*
  Shared types, round counts and GF(2^8) helpers for the AES encipher engine.
  Only AES-128 and AES-256 round counts are covered. AES-192 is not supported.
  The state is big-endian. Word 0 and byte 0 sit in bits 127 down to 96/120.
  Byte index is column * 4 + row, the FIPS-197 column-major order.
*/

package aes_pkg;

  // ---------------------------------------------------------------------
  // basic types
  // ---------------------------------------------------------------------

  // one column of the state, also one s-box word
  typedef logic [31:0] aes_word_t;

  // round number driven out to the key source
  typedef logic [3:0] round_idx_t;

  // the sequencer reads whole words
  // the mixing logic reads single bytes
  typedef union packed {
    aes_word_t [0:3]  words;
    logic [0:15][7:0] bytes;
  } aes_state_t;

  // ---------------------------------------------------------------------
  // round counts
  // ---------------------------------------------------------------------

  localparam round_idx_t AES128_ROUNDS = 4'd10;
  localparam round_idx_t AES256_ROUNDS = 4'd14;

  // subbytes cycles per round, one word each
  localparam int SBOX_WORDS = 4;

  // operation the datapath performs in the current cycle
  typedef enum logic [2:0] {
    OP_IDLE  = 3'd0,
    OP_INIT  = 3'd1,
    OP_SUB   = 3'd2,
    OP_MIX   = 3'd3,
    OP_FINAL = 3'd4
  } round_op_t;

  // ---------------------------------------------------------------------
  // gf(2^8) multiply helpers for mixcolumns
  // ---------------------------------------------------------------------

  // xtime, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gm2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // times 3 is xtime plus the byte itself
  function automatic logic [7:0] gm3(input logic [7:0] b);
    return gm2(b) ^ b;
  endfunction

endpackage
